/* test/frameBuffer_stimulus.txt */
# kind address length color, all hex
# F is a fill command, C checks the next complete frame and has no fields
C
F 05 0a 1234
C
F 00 08 aaaa
F 04 08 5555
C
F 3a 0c 0f0f
F 10 00 ffff
C
F 00 40 c3c3
C
F 20 30 7e81
F 3f 01 0001
C

/* src.f */
+incdir+rtl
rtl/frameBufferPkg.sv
rtl/sramController.sv
rtl/scanoutReader.sv
rtl/fillRenderer.sv
rtl/frameBufferTop.sv
test/sramModel.sv
test/frameBufferTb.sv

/* Bender.yml */
package:
  name: frame_buffer

export_include_dirs:
  - rtl

sources:
  - rtl/frameBufferPkg.sv
  - rtl/sramController.sv
  - rtl/scanoutReader.sv
  - rtl/fillRenderer.sv
  - rtl/frameBufferTop.sv
  - target: test
    files:
      - test/sramModel.sv
      - test/frameBufferTb.sv

/* test/frameBufferTb.sv */
`include "frameBuffer_consts.svh"

module frameBufferTb import frameBufferPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int frameSize = `FRAME_WIDTH * `FRAME_HEIGHT;
    localparam int ackTimeoutCycles = 400;
    localparam int frameTimeoutCycles = 200;
    localparam int pixelTimeoutCycles = 4;

    logic         clk;
    logic         rst;
    logic         cmdReq;
    SramAddress_t cmdAddress;
    FillLength_t  cmdLength;
    SramData_t    cmdColor;
    logic         cmdAck;
    SramData_t    pixel;
    logic         pixelValid;
    logic         frameStart;
    SramAddress_t sramAddress;
    logic         sramOeN;
    logic         sramWeN;
    wire SramData_t sramData;

    SramData_t refFrame [frameSize];
    logic [31:0] lfsrState = 32'h773;

    // Pixel cadence monitor
    logic monitorOn = 1'b0;
    logic lastValid = 1'b0;
    logic seenFrame = 1'b0;
    int pixelCount = 0;

    frameBufferTop frameBufferTop_i (.*);

    sramModel sramModel_i (
        .clk         (clk),
        .sramAddress (sramAddress),
        .sramOeN     (sramOeN),
        .sramWeN     (sramWeN),
        .sramData    (sramData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Errors found");
        $fatal(1, "stopped on timeout");
    endtask

    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic drawBits(input int count, output int value);
        value = 0;
        repeat (count) begin
            value = (value << 1) | lfsrState[0];
            lfsrState = stepLfsr(lfsrState);
        end
    endtask

    task automatic waitAck(input logic level, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > ackTimeoutCycles) begin
                reportTimeout(what);
            end
        end while (cmdAck !== level);
    endtask

    // Always advances at least one cycle before looking
    task automatic waitPixel(input logic needStart, input int limit, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                reportTimeout(what);
            end
        end while (!(pixelValid && (frameStart || !needStart)));
    endtask

    task automatic checkIdleOutputs();
        compare("cmdAck", 0, cmdAck);
        compare("pixelValid", 0, pixelValid);
        compare("frameStart", 0, frameStart);
        compare("sramWeN", 1, sramWeN);
    endtask

    task automatic sendFill(input SramAddress_t address, input FillLength_t length,
                            input SramData_t color);
        int idleCycles;
        drawBits(3, idleCycles);
        repeat (idleCycles) @(negedge clk);
        @(negedge clk);
        cmdAddress = address;
        cmdLength  = length;
        cmdColor   = color;
        cmdReq     = 1'b1;
        waitAck(1'b1, "cmdAck to rise");
        // Ack has to hold while the request is still up
        @(negedge clk);
        compare("cmdAck", 1, cmdAck);
        cmdReq = 1'b0;
        waitAck(1'b0, "cmdAck to fall");
        for (int i = 0; i < length; i++) begin
            refFrame[(address + i) % frameSize] = color;
        end
    endtask

    task automatic checkFrame();
        waitAck(1'b0, "cmdAck low before frame check");
        waitPixel(1'b1, frameTimeoutCycles, "frameStart");
        compare("pixel[0]", refFrame[0], pixel);
        for (int i = 1; i < frameSize; i++) begin
            waitPixel(1'b0, pixelTimeoutCycles, "pixelValid");
            compare($sformatf("pixel[%0d]", i), refFrame[i], pixel);
        end
    endtask

    always @(negedge clk) begin
        if (monitorOn) begin
            compare("pixelValid", {31'b0, ~lastValid}, {31'b0, pixelValid});
            if (frameStart) begin
                compare("pixelValid with frameStart", 1, pixelValid);
            end
            if (pixelValid && frameStart) begin
                if (seenFrame) begin
                    compare("pixels per frame", frameSize, pixelCount);
                end
                seenFrame = 1'b1;
                pixelCount = 1;
            end else if (pixelValid) begin
                pixelCount++;
            end
        end
        lastValid = pixelValid;
    end

    initial begin
        int fd;
        int count;
        int lineCount;
        logic fileDone;
        logic [63:0] token;
        logic [8*128-1:0] lineBuf;
        logic [31:0] address;
        logic [31:0] length;
        logic [31:0] color;

        rst        = 1'b1;
        cmdReq     = 1'b0;
        cmdAddress = '0;
        cmdLength  = '0;
        cmdColor   = '0;
        for (int i = 0; i < frameSize; i++) begin
            refFrame[i] = '0;
        end

        repeat (2) begin
            @(negedge clk);
            checkIdleOutputs();
            compare("sramOeN", 1, sramOeN);
        end
        rst = 1'b0;
        @(negedge clk);
        checkIdleOutputs();

        waitPixel(1'b0, frameTimeoutCycles, "first pixel after reset");
        monitorOn <= 1'b1;

        fd = $fopen("test/frameBuffer_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            $display("Errors found");
            $fatal(1, "no stimulus");
        end

        fileDone = 1'b0;
        lineCount = 0;
        while (!fileDone) begin
            count = $fscanf(fd, "%s", token);
            if (count != 1) begin
                fileDone = 1'b1;
            end else if (token == "#") begin
                count = $fgets(lineBuf, fd);
            end else if (token == "F") begin
                count = $fscanf(fd, "%h %h %h", address, length, color);
                if (count != 3) begin
                    $display("Fill line in the stimulus file is missing fields");
                    $display("Errors found");
                    $fatal(1, "bad stimulus");
                end
                sendFill(address[5:0], length[6:0], color[15:0]);
                lineCount++;
            end else if (token == "C") begin
                checkFrame();
                lineCount++;
            end else begin
                $display("Unknown line kind in the stimulus file");
                $display("Errors found");
                $fatal(1, "bad stimulus");
            end
        end
        $fclose(fd);

        if (lineCount == 0) begin
            $display("Stimulus file held no commands");
            $display("Errors found");
            $fatal(1, "empty stimulus");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* test/sramModel.sv */
`include "frameBuffer_consts.svh"

module sramModel import frameBufferPkg::*; (
    input  logic         clk,
    input  SramAddress_t sramAddress,
    input  logic         sramOeN,
    input  logic         sramWeN,
    inout  SramData_t    sramData
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int memoryDepth = 1 << `SRAM_ADDRESS_WIDTH;

    SramData_t memory [memoryDepth];

    initial begin
        for (int i = 0; i < memoryDepth; i++) begin
            memory[i] = '0;
        end
    end

    // Output enable only counts while no write is in progress
    assign sramData = (!sramOeN && sramWeN) ? memory[sramAddress] : 'z;

    always @(posedge clk) begin
        if (!sramWeN) begin
            memory[sramAddress] <= sramData;
        end
    end

endmodule

/* rtl/frameBufferTop.sv */
module frameBufferTop import frameBufferPkg::*; (
    input  logic         clk,
    input  logic         rst,
    // Fill command port
    input  logic         cmdReq,
    input  SramAddress_t cmdAddress,
    input  FillLength_t  cmdLength,
    input  SramData_t    cmdColor,
    output logic         cmdAck,
    // Display scan output
    output SramData_t    pixel,
    output logic         pixelValid,
    output logic         frameStart,
    // SRAM pins
    output SramAddress_t sramAddress,
    output logic         sramOeN,
    output logic         sramWeN,
    inout  SramData_t    sramData
);

    SramAddress_t readAddress;
    SramData_t    readData;
    logic         readDone;

    SramAddress_t writeAddress;
    SramData_t    writeData;
    logic         writeEnable;
    logic         writeDone;

    sramController sramController_i (
        .clk          (clk),
        .rst          (rst),
        .readAddress  (readAddress),
        .readData     (readData),
        .readDone     (readDone),
        .writeAddress (writeAddress),
        .writeData    (writeData),
        .writeEnable  (writeEnable),
        .writeDone    (writeDone),
        .sramAddress  (sramAddress),
        .sramOeN      (sramOeN),
        .sramWeN      (sramWeN),
        .sramData     (sramData)
    );

    scanoutReader scanoutReader_i (
        .clk          (clk),
        .rst          (rst),
        .readDone     (readDone),
        .readData     (readData),
        .readAddress  (readAddress),
        .pixel        (pixel),
        .pixelValid   (pixelValid),
        .frameStart   (frameStart)
    );

    fillRenderer fillRenderer_i (
        .clk          (clk),
        .rst          (rst),
        .cmdReq       (cmdReq),
        .cmdAddress   (cmdAddress),
        .cmdLength    (cmdLength),
        .cmdColor     (cmdColor),
        .cmdAck       (cmdAck),
        .writeDone    (writeDone),
        .writeAddress (writeAddress),
        .writeData    (writeData),
        .writeEnable  (writeEnable)
    );

endmodule

/* rtl/fillRenderer.sv */
module fillRenderer import frameBufferPkg::*; (
    input  logic         clk,
    input  logic         rst,
    // Four-phase command port
    input  logic         cmdReq,
    input  SramAddress_t cmdAddress,
    input  FillLength_t  cmdLength,
    input  SramData_t    cmdColor,
    output logic         cmdAck,
    // Write slot to the controller
    input  logic         writeDone,
    output SramAddress_t writeAddress,
    output SramData_t    writeData,
    output logic         writeEnable
);

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_FILL,
        STATE_ACK
    } FillRendererState_t;

    FillRendererState_t currentState;
    FillLength_t remaining;

    logic startCmd;
    logic fillDone;

    assign startCmd = (currentState == STATE_IDLE) && cmdReq;
    assign fillDone = (currentState == STATE_FILL) && (remaining == '0);

    assign writeEnable = (currentState == STATE_FILL) && (remaining != '0);
    assign cmdAck      = (currentState == STATE_ACK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            currentState <= STATE_IDLE;
            remaining    <= '0;
        end else begin
            unique case (currentState)
                STATE_IDLE: begin
                    if (cmdReq) begin
                        remaining    <= cmdLength;
                        currentState <= STATE_FILL;
                    end
                end
                STATE_FILL: begin
                    // Zero length falls straight through to the ack
                    if (fillDone) begin
                        currentState <= STATE_ACK;
                    end else if (writeDone) begin
                        remaining <= remaining - FillLength_t'(1);
                    end
                end
                STATE_ACK: begin
                    // Wait for the host to drop its request
                    if (!cmdReq) begin
                        currentState <= STATE_IDLE;
                    end
                end
                default: begin
                    currentState <= STATE_IDLE;
                end
            endcase
        end
    end

    // Address wraps past the last word through the natural 6-bit overflow
    always_ff @(posedge clk) begin
        if (startCmd) begin
            writeAddress <= cmdAddress;
            writeData    <= cmdColor;
        end else if (writeEnable && writeDone) begin
            writeAddress <= writeAddress + SramAddress_t'(1);
        end
    end

endmodule

/* rtl/scanoutReader.sv */
`include "frameBuffer_consts.svh"

module scanoutReader import frameBufferPkg::*; (
    input  logic         clk,
    input  logic         rst,
    // Read slot from the controller
    input  logic         readDone,
    input  SramData_t    readData,
    output SramAddress_t readAddress,
    // Pixel stream
    output SramData_t    pixel,
    output logic         pixelValid,
    output logic         frameStart
);

    SramAddress_t lastAddress;
    logic atFrameEnd;

    // Final raster position of a frame
    assign lastAddress = SramAddress_t'(`FRAME_WIDTH * `FRAME_HEIGHT - 1);
    assign atFrameEnd  = (readAddress == lastAddress);

    // Raster address, steps once per read slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readAddress <= '0;
        end else if (readDone) begin
            if (atFrameEnd) begin
                readAddress <= '0;
            end else begin
                readAddress <= readAddress + SramAddress_t'(1);
            end
        end
    end

    // Strobes trail readDone by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixelValid <= 1'b0;
            frameStart <= 1'b0;
        end else begin
            pixelValid <= readDone;
            frameStart <= readDone && (readAddress == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (readDone) begin
            pixel <= readData;
        end
    end

endmodule

/* rtl/sramController.sv */
module sramController import frameBufferPkg::*; (
    input  logic         clk,
    input  logic         rst,
    // Read slot client
    input  SramAddress_t readAddress,
    output SramData_t    readData,
    output logic         readDone,
    // Write slot client
    input  SramAddress_t writeAddress,
    input  SramData_t    writeData,
    input  logic         writeEnable,
    output logic         writeDone,
    // SRAM pins
    output SramAddress_t sramAddress,
    output logic         sramOeN,
    output logic         sramWeN,
    inout  SramData_t    sramData
);

    SramControllerState_t currentState, nextState;

    SramData_t capturedData;
    logic dataEnable;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            currentState <= STATE_INIT;
        end else begin
            currentState <= nextState;
        end
    end

    // Hold the last read word between read slots
    always_ff @(posedge clk) begin
        if (currentState == STATE_READ_SLOT) begin
            capturedData <= sramData;
        end
    end

    assign readData = (currentState == STATE_READ_SLOT) ? sramData : capturedData;
    assign sramData = dataEnable ? writeData : 'z;

    always_comb begin
        nextState   = STATE_INIT;
        sramAddress = '0;
        sramOeN     = 1'b1;
        sramWeN     = 1'b1;
        dataEnable  = 1'b0;
        readDone    = 1'b0;
        writeDone   = 1'b0;
        unique case (currentState)
            STATE_INIT: begin
                nextState = STATE_READ_SLOT;
            end
            STATE_READ_SLOT: begin
                sramAddress = readAddress;
                sramOeN     = 1'b0;
                readDone    = 1'b1;
                nextState   = STATE_WRITE_SLOT;
            end
            STATE_WRITE_SLOT: begin
                // Idle write slot leaves the bus released
                sramAddress = writeAddress;
                sramWeN     = ~writeEnable;
                dataEnable  = writeEnable;
                writeDone   = writeEnable;
                nextState   = STATE_READ_SLOT;
            end
            default: begin
                nextState = STATE_INIT;
            end
        endcase
    end

endmodule

/* rtl/frameBufferPkg.sv */
`include "frameBuffer_consts.svh"

package frameBufferPkg;

    // Word address into the SRAM
    typedef logic [`SRAM_ADDRESS_WIDTH-1:0] SramAddress_t;

    // One SRAM word, also one pixel color
    typedef logic [`SRAM_DATA_WIDTH-1:0] SramData_t;

    // Word count of one fill command
    typedef logic [`FILL_LENGTH_WIDTH-1:0] FillLength_t;

    typedef enum logic [1:0] {
        STATE_INIT,
        STATE_READ_SLOT,
        STATE_WRITE_SLOT
    } SramControllerState_t;

endpackage

/* rtl/frameBuffer_consts.svh */
`ifndef FRAME_BUFFER_CONSTS_SVH
`define FRAME_BUFFER_CONSTS_SVH

// SRAM geometry
`define SRAM_ADDRESS_WIDTH 6
`define SRAM_DATA_WIDTH 16

// Frame geometry, product must fill the address space
`define FRAME_WIDTH 16
`define FRAME_HEIGHT 4

// Wide enough for a full-frame fill of 64 words
`define FILL_LENGTH_WIDTH 7

`endif
